/* include/mfp_config.svh */
`ifndef MFP_CONFIG_SVH
`define MFP_CONFIG_SVH

// address map
`define MFP_RAM_BASE           32'h0000_0000
`define MFP_RAM_MASK_BITS      20
`define MFP_RAM_ADDR_WIDTH     10    // 1K words fills the 4 KB region
`define MFP_GPIO_BASE          32'h1F80_0000
`define MFP_GPIO_MASK_BITS     20
`define MFP_GPIO_OFFSET_WIDTH  (32 - `MFP_GPIO_MASK_BITS)

// board pins
`define MFP_WIDTH_SW           18
`define MFP_WIDTH_BTN          5
`define MFP_WIDTH_LEDR         18
`define MFP_WIDTH_LEDG         8

// program loader serial line
`define MFP_UART_CLKS_PER_BIT  16
`define MFP_UART_IDLE_BITS     20    // quiet time that closes a session

`endif

/* logic/mfp_ahb_pkg.sv */
`include "mfp_config.svh"

package mfp_ahb_pkg;

    typedef logic [31:0] haddr_t;
    typedef logic [31:0] hdata_t;

    typedef enum logic [1:0] {
        HTRANS_IDLE   = 2'b00,
        HTRANS_BUSY   = 2'b01,
        HTRANS_NONSEQ = 2'b10,
        HTRANS_SEQ    = 2'b11
    } htrans_t;

    typedef logic [2:0] hsize_t;

    // only word transfers on this fabric
    localparam hsize_t HSIZE_WORD = 3'd2;

    typedef logic [`MFP_RAM_ADDR_WIDTH-1:0] ram_addr_t;

endpackage

/* logic/mfp_board_pkg.sv */
`include "mfp_config.svh"

package mfp_board_pkg;

    typedef logic [`MFP_WIDTH_SW-1:0]   sw_t;
    typedef logic [`MFP_WIDTH_BTN-1:0]  btn_t;
    typedef logic [`MFP_WIDTH_LEDR-1:0] ledr_t;
    typedef logic [`MFP_WIDTH_LEDG-1:0] ledg_t;
    typedef logic [31:0]                seg_t;

    // byte offsets inside the gpio region
    typedef enum logic [`MFP_GPIO_OFFSET_WIDTH-1:0] {
        GPIO_LEDR = 'h00,
        GPIO_LEDG = 'h04,
        GPIO_SEG  = 'h08,
        GPIO_SW   = 'h0C,
        GPIO_BTN  = 'h10
    } gpio_reg_t;

endpackage

/* logic/mfp_ahb_if.sv */
`timescale 1ns/1ps

interface mfp_ahb_if import mfp_ahb_pkg::*; ();

    haddr_t  haddr;
    htrans_t htrans;
    logic    hwrite;
    hsize_t  hsize;
    hdata_t  hwdata;     // data phase
    logic    ram_sel;    // address phase decode
    logic    gpio_sel;
    hdata_t  ram_rdata;
    hdata_t  gpio_rdata;

    modport ctrl (
        output haddr, htrans, hwrite, hsize, hwdata, ram_sel, gpio_sel,
        input  ram_rdata, gpio_rdata
    );

    modport ram (
        input  haddr, htrans, hwrite, hwdata, ram_sel,
        output ram_rdata
    );

    modport gpio (
        input  haddr, htrans, hwrite, hwdata, gpio_sel,
        output gpio_rdata
    );

endinterface

/* logic/mfp_bus_control.sv */
`timescale 1ns/1ps
`include "mfp_config.svh"

module mfp_bus_control import mfp_ahb_pkg::*; (
    input  logic    hclk,
    input  logic    arst_n,
    input  haddr_t  cpu_haddr,
    input  htrans_t cpu_htrans,
    input  logic    cpu_hwrite,
    input  hsize_t  cpu_hsize,
    input  hdata_t  cpu_hwdata,
    output hdata_t  cpu_hrdata,
    input  logic    memory_load,
    input  logic    load_valid,
    input  haddr_t  load_addr,
    input  hdata_t  load_data,
    output logic    cpu_reset_n,
    mfp_ahb_if.ctrl bus
);
    localparam haddr_t RAM_BASE  = `MFP_RAM_BASE;
    localparam haddr_t GPIO_BASE = `MFP_GPIO_BASE;
    localparam int     RAM_HI    = `MFP_RAM_MASK_BITS;
    localparam int     GPIO_HI   = `MFP_GPIO_MASK_BITS;

    logic addr_phase;
    logic dphase_load;      // loader write in data phase
    logic dphase_ram_rd;
    logic dphase_gpio_rd;

    // loader owns the bus for the whole session, cpu is ignored
    always_comb begin
        if (memory_load) begin
            bus.haddr  = load_addr;
            bus.htrans = load_valid ? HTRANS_NONSEQ : HTRANS_IDLE;
            bus.hwrite = 1'b1;
            bus.hsize  = HSIZE_WORD;
        end else begin
            bus.haddr  = cpu_haddr;
            bus.htrans = cpu_htrans;
            bus.hwrite = cpu_hwrite;
            bus.hsize  = cpu_hsize;
        end
    end

    assign bus.hwdata = dphase_load ? load_data : cpu_hwdata;

    assign bus.ram_sel  = bus.haddr[31 -: RAM_HI]  == RAM_BASE[31 -: RAM_HI];
    assign bus.gpio_sel = bus.haddr[31 -: GPIO_HI] == GPIO_BASE[31 -: GPIO_HI];

    assign addr_phase = bus.htrans == HTRANS_NONSEQ;

    always_ff @(posedge hclk or negedge arst_n) begin
        if (!arst_n) begin
            dphase_load    <= 1'b0;
            dphase_ram_rd  <= 1'b0;
            dphase_gpio_rd <= 1'b0;
            cpu_reset_n    <= 1'b1;
        end else begin
            dphase_load    <= memory_load && load_valid;
            dphase_ram_rd  <= addr_phase && !bus.hwrite && bus.ram_sel;
            dphase_gpio_rd <= addr_phase && !bus.hwrite && bus.gpio_sel;
            cpu_reset_n    <= !memory_load;   // cpu held while loading
        end
    end

    // unmapped reads return 0
    always_comb begin
        if (dphase_ram_rd)
            cpu_hrdata = bus.ram_rdata;
        else if (dphase_gpio_rd)
            cpu_hrdata = bus.gpio_rdata;
        else
            cpu_hrdata = '0;
    end

    // whichever master owns the bus, transfers are words
    assert property (@(posedge hclk) disable iff (!arst_n)
        bus.htrans == HTRANS_NONSEQ |-> bus.hsize == HSIZE_WORD);

endmodule

/* logic/mfp_uart_programmer.sv */
`timescale 1ns/1ps
`include "mfp_config.svh"

module mfp_uart_programmer import mfp_ahb_pkg::*; (
    input  logic   hclk,
    input  logic   arst_n,
    input  logic   uart_prg_rx,
    output logic   memory_load,
    output logic   load_valid,
    output haddr_t load_addr,
    output hdata_t load_data
);
    localparam int CLKS_PER_BIT = `MFP_UART_CLKS_PER_BIT;
    localparam int IDLE_CLKS    = `MFP_UART_IDLE_BITS * CLKS_PER_BIT;

    typedef logic [$clog2(CLKS_PER_BIT)-1:0] clk_cnt_t;
    typedef logic [$clog2(IDLE_CLKS+1)-1:0]  idle_cnt_t;
    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

    rx_state_t   state;
    logic        rx_meta;
    logic        rx_sync;
    clk_cnt_t    clk_cnt;
    logic        bit_end;
    logic [2:0]  bit_idx;
    logic [7:0]  rx_byte;
    logic [2:0]  byte_idx;   // position in the 8-byte record
    logic [63:0] record;     // address bytes first, lsb first
    idle_cnt_t   idle_cnt;

    assign bit_end   = clk_cnt == clk_cnt_t'(CLKS_PER_BIT - 1);
    assign load_addr = record[31:0];
    assign load_data = record[63:32];

    always_ff @(posedge hclk or negedge arst_n) begin
        if (!arst_n) begin
            rx_meta     <= 1'b1;
            rx_sync     <= 1'b1;
            state       <= RX_IDLE;
            clk_cnt     <= '0;
            bit_idx     <= '0;
            rx_byte     <= '0;
            byte_idx    <= '0;
            record      <= '0;
            idle_cnt    <= '0;
            memory_load <= 1'b0;
            load_valid  <= 1'b0;
        end else begin
            rx_meta    <= uart_prg_rx;
            rx_sync    <= rx_meta;
            load_valid <= 1'b0;
            clk_cnt    <= clk_cnt + 1'b1;
            case (state)
                RX_IDLE: begin
                    clk_cnt <= '0;
                    if (!rx_sync) begin
                        state       <= RX_START;
                        memory_load <= 1'b1;
                        idle_cnt    <= '0;
                    end else if (memory_load) begin
                        if (idle_cnt == idle_cnt_t'(IDLE_CLKS - 1)) begin
                            memory_load <= 1'b0;   // session over
                            byte_idx    <= '0;
                            idle_cnt    <= '0;
                        end else begin
                            idle_cnt <= idle_cnt + 1'b1;
                        end
                    end
                end
                RX_START: if (clk_cnt == clk_cnt_t'(CLKS_PER_BIT / 2 - 1)) begin
                    clk_cnt <= '0;
                    bit_idx <= '0;
                    state   <= rx_sync ? RX_IDLE : RX_DATA;  // glitch if high
                end
                RX_DATA: if (bit_end) begin
                    rx_byte <= {rx_sync, rx_byte[7:1]};
                    bit_idx <= bit_idx + 1'b1;
                    if (bit_idx == 3'd7)
                        state <= RX_STOP;
                end
                RX_STOP: if (bit_end) begin
                    state <= RX_IDLE;
                    if (rx_sync) begin   // framing errors are dropped
                        record     <= {rx_byte, record[63:8]};
                        byte_idx   <= byte_idx + 1'b1;
                        load_valid <= byte_idx == 3'd7;
                    end
                end
            endcase
        end
    end

    assert property (@(posedge hclk) disable iff (!arst_n) load_valid |-> memory_load);

endmodule

/* logic/mfp_ahb_ram.sv */
`timescale 1ns/1ps

module mfp_ahb_ram import mfp_ahb_pkg::*; (
    input  logic   hclk,
    input  logic   arst_n,
    mfp_ahb_if.ram bus
);
    localparam int WORDS = 2 ** $bits(ram_addr_t);

    hdata_t    mem [WORDS];
    ram_addr_t addr_q;       // word index of the data phase
    logic      wr_q;
    logic      access;

    assign access = bus.ram_sel && bus.htrans == HTRANS_NONSEQ;

    always_ff @(posedge hclk or negedge arst_n) begin
        if (!arst_n)
            wr_q <= 1'b0;
        else
            wr_q <= access && bus.hwrite;
    end

    always_ff @(posedge hclk) begin
        if (access)
            addr_q <= bus.haddr[$bits(ram_addr_t)+1:2];
        if (wr_q)
            mem[addr_q] <= bus.hwdata;   // old index, next transfer may latch now
    end

    // zero wait, read straight from the array
    assign bus.ram_rdata = mem[addr_q];

endmodule

/* logic/mfp_gpio.sv */
`timescale 1ns/1ps

module mfp_gpio import mfp_ahb_pkg::*, mfp_board_pkg::*; (
    input  logic    hclk,
    input  logic    arst_n,
    mfp_ahb_if.gpio bus,
    input  sw_t     pin_sw,
    input  btn_t    pin_btn,
    output ledr_t   pin_ledr,
    output ledg_t   pin_ledg,
    output seg_t    pin_seg
);
    gpio_reg_t reg_q;
    logic      wr_q;
    logic      access;

    assign access = bus.gpio_sel && bus.htrans == HTRANS_NONSEQ;

    always_ff @(posedge hclk or negedge arst_n) begin
        if (!arst_n) begin
            reg_q    <= GPIO_LEDR;
            wr_q     <= 1'b0;
            pin_ledr <= '0;
            pin_ledg <= '0;
            pin_seg  <= '0;
        end else begin
            wr_q <= access && bus.hwrite;
            if (access)
                reg_q <= gpio_reg_t'(bus.haddr[$bits(gpio_reg_t)-1:0]);
            if (wr_q) begin
                case (reg_q)
                    GPIO_LEDR: pin_ledr <= bus.hwdata[$bits(ledr_t)-1:0];
                    GPIO_LEDG: pin_ledg <= bus.hwdata[$bits(ledg_t)-1:0];
                    GPIO_SEG:  pin_seg  <= bus.hwdata;
                    default: ;   // inputs and holes ignore writes
                endcase
            end
        end
    end

    // switches and buttons are read live
    always_comb begin
        case (reg_q)
            GPIO_LEDR: bus.gpio_rdata = hdata_t'(pin_ledr);
            GPIO_LEDG: bus.gpio_rdata = hdata_t'(pin_ledg);
            GPIO_SEG:  bus.gpio_rdata = hdata_t'(pin_seg);
            GPIO_SW:   bus.gpio_rdata = hdata_t'(pin_sw);
            GPIO_BTN:  bus.gpio_rdata = hdata_t'(pin_btn);
            default:   bus.gpio_rdata = '0;
        endcase
    end

    assert property (@(posedge hclk) disable iff (!arst_n)
        wr_q |-> !(reg_q inside {GPIO_SW, GPIO_BTN}));

endmodule

/* logic/mfp_system.sv */
`timescale 1ns/1ps

module mfp_system import mfp_ahb_pkg::*, mfp_board_pkg::*; (
    input  logic    hclk,
    input  logic    arst_n,

    input  haddr_t  cpu_haddr,
    input  htrans_t cpu_htrans,
    input  logic    cpu_hwrite,
    input  hsize_t  cpu_hsize,
    input  hdata_t  cpu_hwdata,
    output hdata_t  cpu_hrdata,

    input  logic    uart_prg_rx,
    output logic    cpu_reset_n,
    output logic    memory_load,

    input  sw_t     pin_sw,
    input  btn_t    pin_btn,
    output ledr_t   pin_ledr,
    output ledg_t   pin_ledg,
    output seg_t    pin_seg
);
    logic   load_valid;
    haddr_t load_addr;
    hdata_t load_data;

    mfp_ahb_if bus ();

    mfp_bus_control bus_control (
        .hclk        ( hclk        ),
        .arst_n      ( arst_n      ),
        .cpu_haddr   ( cpu_haddr   ),
        .cpu_htrans  ( cpu_htrans  ),
        .cpu_hwrite  ( cpu_hwrite  ),
        .cpu_hsize   ( cpu_hsize   ),
        .cpu_hwdata  ( cpu_hwdata  ),
        .cpu_hrdata  ( cpu_hrdata  ),
        .memory_load ( memory_load ),
        .load_valid  ( load_valid  ),
        .load_addr   ( load_addr   ),
        .load_data   ( load_data   ),
        .cpu_reset_n ( cpu_reset_n ),
        .bus         ( bus.ctrl    )
    );

    // serial loader, owns the bus during a session
    mfp_uart_programmer uart_programmer (
        .hclk        ( hclk        ),
        .arst_n      ( arst_n      ),
        .uart_prg_rx ( uart_prg_rx ),
        .memory_load ( memory_load ),
        .load_valid  ( load_valid  ),
        .load_addr   ( load_addr   ),
        .load_data   ( load_data   )
    );

    mfp_ahb_ram ram (
        .hclk   ( hclk    ),
        .arst_n ( arst_n  ),
        .bus    ( bus.ram )
    );

    mfp_gpio gpio (
        .hclk     ( hclk     ),
        .arst_n   ( arst_n   ),
        .bus      ( bus.gpio ),
        .pin_sw   ( pin_sw   ),
        .pin_btn  ( pin_btn  ),
        .pin_ledr ( pin_ledr ),
        .pin_ledg ( pin_ledg ),
        .pin_seg  ( pin_seg  )
    );

endmodule

/* verification/tb_mfp_system.sv */
`timescale 1ns/1ps
`include "mfp_config.svh"

module tb_mfp_system import mfp_ahb_pkg::*, mfp_board_pkg::*;;
    localparam int     CLK_PERIOD  = 100;
    localparam int     BIT_CLKS    = `MFP_UART_CLKS_PER_BIT;
    localparam int     RAM_PAIRS   = 16;
    localparam int     BUS_CYCLES  = 160 + 3 * RAM_PAIRS;
    localparam int     UART_BITS   = 3 * 8 * 10 + `MFP_UART_IDLE_BITS + 2;
    localparam longint WATCHDOG_NS = longint'(2 * (BUS_CYCLES + UART_BITS * BIT_CLKS) * CLK_PERIOD);
    localparam int     OFS_W       = 32 - `MFP_GPIO_MASK_BITS;
    localparam haddr_t RAM_BASE    = `MFP_RAM_BASE;
    localparam haddr_t GPIO_BASE   = `MFP_GPIO_BASE;
    localparam haddr_t UNMAPPED    = 32'h4000_0000;

    logic hclk, arst_n, cpu_hwrite, uart_prg_rx, cpu_reset_n, memory_load;
    haddr_t cpu_haddr;
    htrans_t cpu_htrans;
    hsize_t cpu_hsize;
    hdata_t cpu_hwdata, cpu_hrdata;
    sw_t pin_sw;
    btn_t pin_btn;
    ledr_t pin_ledr;
    ledg_t pin_ledg;
    seg_t pin_seg;

    // transfer in address phase, then in data phase
    logic   ap_valid = 1'b0, ap_wr = 1'b0, ap_apply = 1'b0;
    haddr_t ap_addr = '0;
    hdata_t ap_wdata = '0;
    logic   dp_wr = 1'b0, dp_apply = 1'b0, dp_chk = 1'b0;
    haddr_t dp_addr = '0;
    hdata_t dp_wdata = '0, dp_exp = '0;

    // shadow model
    hdata_t ram_model [ram_addr_t];
    ledr_t  exp_ledr = '0;
    ledg_t  exp_ledg = '0;
    seg_t   exp_seg = '0;

    logic [15:0] lfsr = 16'd36829;
    logic  idle_exp = 1'b1, loading = 1'b0;
    string test_name = "reset";
    int    errors = 0, errors_seen = 0, tests_run = 0, tests_failed = 0;

    mfp_system mfp_system_inst (.*);

    initial begin
        hclk = 1'b0;
        forever #(CLK_PERIOD / 2) hclk = ~hclk;
    end

    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] bits;
        logic        out;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            out  = lfsr[0];
            lfsr = {1'b0, lfsr[15:1]} ^ (out ? 16'hB400 : 16'h0000);
            bits = {bits[30:0], out};
        end
        return bits;
    endfunction

    function automatic logic in_ram(input haddr_t a);
        return a[31 -: `MFP_RAM_MASK_BITS] == RAM_BASE[31 -: `MFP_RAM_MASK_BITS];
    endfunction

    function automatic logic in_gpio(input haddr_t a);
        return a[31 -: `MFP_GPIO_MASK_BITS] == GPIO_BASE[31 -: `MFP_GPIO_MASK_BITS];
    endfunction

    function automatic void apply_write(input haddr_t a, input hdata_t d);
        if (in_ram(a))
            ram_model[ram_addr_t'(a >> 2)] = d;
        else if (in_gpio(a))
            case (a[OFS_W-1:0])
                'h0: exp_ledr = ledr_t'(d);
                'h4: exp_ledg = ledg_t'(d);
                'h8: exp_seg = d;
                default: ;   // read-only or hole
            endcase
    endfunction

    function automatic hdata_t expected_read(input haddr_t a);
        if (in_ram(a))
            return ram_model[ram_addr_t'(a >> 2)];
        if (in_gpio(a))
            case (a[OFS_W-1:0])
                'h0: return hdata_t'(exp_ledr);
                'h4: return hdata_t'(exp_ledg);
                'h8: return exp_seg;
                'hC: return hdata_t'(pin_sw);
                'h10: return hdata_t'(pin_btn);
                default: return '0;
            endcase
        return '0;
    endfunction

    // model update at the edge that ends a write data phase
    always @(posedge hclk) begin
        if (dp_wr && dp_apply)
            apply_write(dp_addr, dp_wdata);
        cpu_hwdata <= ap_wdata;
        dp_wr      <= ap_valid && ap_wr;
        dp_apply   <= ap_apply;
        dp_addr    <= ap_addr;
        dp_wdata   <= ap_wdata;
        dp_chk     <= ap_valid && !ap_wr;
        if (ap_valid && !ap_wr)
            dp_exp <= expected_read(ap_addr);   // sees the write just retired
    end

    assert property (@(posedge hclk) disable iff (!arst_n) dp_chk |-> cpu_hrdata == dp_exp)
        else begin
            errors++;
            $display("MISMATCH %s read expected %h actual %h", test_name,
                     $sampled(dp_exp), $sampled(cpu_hrdata));
        end
    assert property (@(posedge hclk) disable iff (!arst_n) pin_ledr == exp_ledr)
        else begin
            errors++;
            $display("MISMATCH %s pin_ledr expected %h actual %h", test_name,
                     $sampled(exp_ledr), $sampled(pin_ledr));
        end
    assert property (@(posedge hclk) disable iff (!arst_n) pin_ledg == exp_ledg)
        else begin
            errors++;
            $display("MISMATCH %s pin_ledg expected %h actual %h", test_name,
                     $sampled(exp_ledg), $sampled(pin_ledg));
        end
    assert property (@(posedge hclk) disable iff (!arst_n) pin_seg == exp_seg)
        else begin
            errors++;
            $display("MISMATCH %s pin_seg expected %h actual %h", test_name,
                     $sampled(exp_seg), $sampled(pin_seg));
        end
    assert property (@(posedge hclk) disable iff (!arst_n)
        idle_exp |-> !memory_load && cpu_reset_n)
        else begin
            errors++;
            $display("%s: loader still active or cpu held in reset when idle", test_name);
        end
    assert property (@(posedge hclk) disable iff (!arst_n)
        loading |-> memory_load && !cpu_reset_n)
        else begin
            errors++;
            $display("%s: memory_load low or cpu not held in reset during load", test_name);
        end

    task automatic write_word(input haddr_t a, input hdata_t d, input logic apply = 1'b1);
        @(posedge hclk);
        cpu_haddr  <= a;
        cpu_htrans <= HTRANS_NONSEQ;
        cpu_hwrite <= 1'b1;
        ap_valid   <= 1'b1;
        ap_wr      <= 1'b1;
        ap_apply   <= apply;
        ap_addr    <= a;
        ap_wdata   <= d;
    endtask

    task automatic read_word(input haddr_t a);
        @(posedge hclk);
        cpu_haddr  <= a;
        cpu_htrans <= HTRANS_NONSEQ;
        cpu_hwrite <= 1'b0;
        ap_valid   <= 1'b1;
        ap_wr      <= 1'b0;
        ap_apply   <= 1'b0;
        ap_addr    <= a;
        ap_wdata   <= '0;
    endtask

    task automatic idle_bus(input int cycles);
        repeat (cycles) begin
            @(posedge hclk);
            cpu_htrans <= HTRANS_IDLE;
            ap_valid   <= 1'b0;
        end
    endtask

    task automatic send_byte(input logic [7:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};   // stop, data lsb first, start
        for (int i = 0; i < 10; i++) begin
            @(posedge hclk);
            uart_prg_rx <= frame[i];
            repeat (BIT_CLKS - 1) @(posedge hclk);
        end
    endtask

    task automatic send_record(input haddr_t a, input hdata_t d);
        logic [63:0] rec;
        rec = {d, a};
        for (int i = 0; i < 8; i++)
            send_byte(rec[8*i +: 8]);
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        errors_seen = errors;
    endtask

    task automatic finish_test();
        repeat (2) @(posedge hclk);
        tests_run++;
        if (errors != errors_seen)
            tests_failed++;
        $display("%-12s %s", test_name, (errors == errors_seen) ? "ok" : "failed");
    endtask

    initial begin
        haddr_t addr;
        hdata_t data;
        haddr_t ram_addrs[$];
        haddr_t rec_addr[3];
        hdata_t rec_data[3];

        arst_n = 1'b0;
        cpu_haddr = '0;
        cpu_htrans = HTRANS_IDLE;
        cpu_hwrite = 1'b0;
        cpu_hsize = HSIZE_WORD;
        cpu_hwdata = '0;
        uart_prg_rx = 1'b1;
        pin_sw = '0;
        pin_btn = '0;
        repeat (10) @(posedge hclk);
        arst_n <= 1'b1;

        start_test("reset");
        repeat (4) @(posedge hclk);
        finish_test();

        start_test("ram");
        for (int i = 0; i < RAM_PAIRS; i++) begin
            addr = RAM_BASE + (lfsr_bits(10) << 2);
            data = lfsr_bits(32);
            ram_addrs.push_back(addr);
            write_word(addr, data);
            read_word(addr);   // back to back
        end
        idle_bus(1);
        foreach (ram_addrs[i])
            read_word(ram_addrs[i]);
        idle_bus(2);
        finish_test();

        start_test("gpio_write");
        for (int i = 0; i < 4; i++) begin
            write_word(GPIO_BASE + 'h0, lfsr_bits(32));
            write_word(GPIO_BASE + 'h4, lfsr_bits(32));
            write_word(GPIO_BASE + 'h8, lfsr_bits(32));
            read_word(GPIO_BASE + 'h0);
            read_word(GPIO_BASE + 'h4);
            read_word(GPIO_BASE + 'h8);
        end
        idle_bus(2);
        finish_test();

        start_test("gpio_read");
        @(posedge hclk);
        pin_sw  <= sw_t'(lfsr_bits(18));
        pin_btn <= btn_t'(lfsr_bits(5));
        read_word(GPIO_BASE + 'hC);
        read_word(GPIO_BASE + 'h10);
        read_word(GPIO_BASE + 'h14);
        read_word(UNMAPPED);
        read_word(RAM_BASE + 32'h1000);   // just past the ram region
        write_word(UNMAPPED | ram_addrs[0], lfsr_bits(32));
        write_word(RAM_BASE + 32'h1000 + ram_addrs[1], lfsr_bits(32));
        write_word(GPIO_BASE + 'h14, lfsr_bits(32));
        read_word(ram_addrs[0]);
        read_word(ram_addrs[1]);
        idle_bus(2);
        finish_test();

        start_test("uart_load");
        for (int r = 0; r < 3; r++) begin
            rec_addr[r] = RAM_BASE + (lfsr_bits(10) << 2);
            rec_data[r] = lfsr_bits(32);
        end
        @(posedge hclk);
        idle_exp <= 1'b0;
        for (int r = 0; r < 3; r++) begin
            send_record(rec_addr[r], rec_data[r]);
            apply_write(rec_addr[r], rec_data[r]);
            loading <= 1'b1;
            // cpu writes while the loader owns the bus
            write_word(rec_addr[r], ~rec_data[r], 1'b0);
            write_word(ram_addrs[r], lfsr_bits(32), 1'b0);
            write_word(GPIO_BASE, lfsr_bits(32), 1'b0);
            idle_bus(1);
        end
        loading <= 1'b0;
        repeat ((`MFP_UART_IDLE_BITS + 2) * BIT_CLKS) @(posedge hclk);
        idle_exp <= 1'b1;
        for (int r = 0; r < 3; r++)
            read_word(rec_addr[r]);
        idle_bus(2);
        finish_test();

        start_test("cpu_ignored");
        for (int r = 0; r < 3; r++)
            read_word(ram_addrs[r]);
        read_word(GPIO_BASE);
        idle_bus(2);
        finish_test();

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0 && tests_failed == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the run did not complete", WATCHDOG_NS);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

/* list.f */
+incdir+include
logic/mfp_ahb_pkg.sv
logic/mfp_board_pkg.sv
logic/mfp_ahb_if.sv
logic/mfp_bus_control.sv
logic/mfp_uart_programmer.sv
logic/mfp_ahb_ram.sv
logic/mfp_gpio.sv
logic/mfp_system.sv
verification/tb_mfp_system.sv

/* Bender.yml */
package:
  name: mfp_system

sources:
  - include_dirs:
      - include
    files:
      - logic/mfp_ahb_pkg.sv
      - logic/mfp_board_pkg.sv
      - logic/mfp_ahb_if.sv
      - logic/mfp_bus_control.sv
      - logic/mfp_uart_programmer.sv
      - logic/mfp_ahb_ram.sv
      - logic/mfp_gpio.sv
      - logic/mfp_system.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/tb_mfp_system.sv
